/* design/spi_slave_pkg.sv */
package spi_slave_pkg;

    // host side word
    localparam int word_bits = 32;

    // character widths, shift registers are sized for the widest one
    localparam int char_min_bits = 8;
    localparam int char_max_bits = 16;

    // characters packed into one word, first character in the low lane
    localparam int chars_per_word_8  = word_bits / char_min_bits;
    localparam int chars_per_word_16 = word_bits / char_max_bits;

    localparam int bit_idx_bits  = $clog2(char_max_bits);
    localparam int char_idx_bits = $clog2(chars_per_word_8);

    // flops per pin synchronizer
    localparam int sync_stages = 2;

    // sent on MISO while no tx word is loaded
    localparam logic [char_max_bits-1:0] idle_char = '1;
    localparam logic [word_bits-1:0] idle_word = {chars_per_word_16{idle_char}};

    // {cpol, cpha}
    typedef enum logic [1:0] {
        spi_mode_0 = 2'b00,
        spi_mode_1 = 2'b01,
        spi_mode_2 = 2'b10,
        spi_mode_3 = 2'b11
    } spi_mode_t;

endpackage

/* design/spi_pin_sync.sv */
module spi_pin_sync
    import spi_slave_pkg::*;
(
    input  logic S_REV,
    input  logic S_RESETN,
    input  logic enable,
    input  logic cpol,
    input  logic cpha,
    input  logic spi_sck,
    input  logic spi_cs,
    input  logic spi_mosi,
    output logic cs_active,
    output logic cs_start,
    output logic sample_edge,
    output logic shift_edge,
    output logic mosi_s
);

    logic [sync_stages-1:0] sck_sync;
    logic [sync_stages-1:0] cs_sync;
    logic [sync_stages-1:0] mosi_sync;
    logic                   sck_prev;
    logic                   sck_s;
    logic                   sck_rise;
    logic                   sck_fall;
    logic                   cs_now;
    logic                   rise_samples;
    spi_mode_t              mode;

    assign sck_s    = sck_sync[sync_stages-1];
    assign mosi_s   = mosi_sync[sync_stages-1];
    assign sck_rise = sck_s & ~sck_prev;
    assign sck_fall = ~sck_s & sck_prev;
    assign cs_now   = enable & ~cs_sync[sync_stages-1]; // cs is active low
    assign mode     = spi_mode_t'({cpol, cpha});

    // leading edge samples for cpha 0, trailing edge for cpha 1
    always_comb begin
        case (mode)
            spi_mode_0: rise_samples = 1'b1;
            spi_mode_1: rise_samples = 1'b0;
            spi_mode_2: rise_samples = 1'b0;
            spi_mode_3: rise_samples = 1'b1;
            default:    rise_samples = 1'b1;
        endcase
    end

    always_ff @(posedge S_REV or negedge S_RESETN) begin
        if (!S_RESETN) begin
            sck_sync    <= '0;
            cs_sync     <= '1;  // deselected
            mosi_sync   <= '0;
            sck_prev    <= 1'b0;
            cs_active   <= 1'b0;
            cs_start    <= 1'b0;
            sample_edge <= 1'b0;
            shift_edge  <= 1'b0;
        end else begin
            sck_sync    <= {sck_sync[sync_stages-2:0], spi_sck};
            cs_sync     <= {cs_sync[sync_stages-2:0], spi_cs};
            mosi_sync   <= {mosi_sync[sync_stages-2:0], spi_mosi};
            sck_prev    <= sck_s;
            cs_active   <= cs_now;
            cs_start    <= cs_now & ~cs_active;
            sample_edge <= cs_now & (rise_samples ? sck_rise : sck_fall);
            shift_edge  <= cs_now & (rise_samples ? sck_fall : sck_rise);
        end
    end

endmodule

/* design/spi_slave_trx_char.sv */
module spi_slave_trx_char
    import spi_slave_pkg::*;
(
    input  logic                     S_REV,
    input  logic                     S_RESETN,
    input  logic                     cpha,
    input  logic                     lsb_first,
    input  logic                     char_16,
    input  logic                     cs_active,
    input  logic                     cs_start,
    input  logic                     sample_edge,
    input  logic                     shift_edge,
    input  logic                     mosi_s,
    input  logic [char_max_bits-1:0] tx_char,
    output logic [char_max_bits-1:0] rx_char,
    output logic                     char_done,
    output logic                     spi_miso
);

    logic [bit_idx_bits-1:0]  bit_idx;
    logic [bit_idx_bits-1:0]  top_idx;
    logic [bit_idx_bits-1:0]  start_idx;
    logic [bit_idx_bits-1:0]  last_idx;
    logic [char_max_bits-1:0] rx_shift;
    logic                     hold_first;
    logic                     at_last;

    assign top_idx   = char_16 ? bit_idx_bits'(char_max_bits - 1)
                               : bit_idx_bits'(char_min_bits - 1);
    assign start_idx = lsb_first ? '0 : top_idx;
    assign last_idx  = lsb_first ? top_idx : '0;
    assign at_last   = (bit_idx == last_idx);

    assign rx_char  = rx_shift;
    assign spi_miso = cs_active ? tx_char[bit_idx] : 1'b1; // idle high when deselected

    always_ff @(posedge S_REV or negedge S_RESETN) begin
        if (!S_RESETN) begin
            bit_idx    <= '0;
            hold_first <= 1'b0;
            char_done  <= 1'b0;
        end else begin
            char_done <= 1'b0;
            if (cs_start) begin
                bit_idx    <= start_idx;
                hold_first <= cpha; // first shift only presents bit 0
            end else if (cs_active) begin
                if (sample_edge && at_last) begin
                    char_done <= 1'b1;
                end
                if (shift_edge) begin
                    if (hold_first) begin
                        hold_first <= 1'b0;
                    end else if (at_last) begin
                        bit_idx <= start_idx; // next character
                    end else if (lsb_first) begin
                        bit_idx <= bit_idx + 1'b1;
                    end else begin
                        bit_idx <= bit_idx - 1'b1;
                    end
                end
            end
        end
    end

    // receive bits land at their final position, no shifting needed
    always_ff @(posedge S_REV) begin
        if (cs_active && sample_edge) begin
            rx_shift[bit_idx] <= mosi_s;
        end
    end

endmodule

/* design/spi_char_packer.sv */
module spi_char_packer
    import spi_slave_pkg::*;
(
    input  logic                     S_REV,
    input  logic                     S_RESETN,
    input  logic                     char_16,
    input  logic                     cs_active,
    input  logic                     cs_start,
    input  logic                     char_done,
    input  logic [char_max_bits-1:0] rx_char,
    input  logic                     rx_ready,
    input  logic                     tx_valid,
    input  logic [word_bits-1:0]     tx_word,
    output logic                     rx_valid,
    output logic [word_bits-1:0]     rx_word,
    output logic                     rx_overrun,
    output logic                     tx_ready,
    output logic [char_max_bits-1:0] tx_char
);

    logic [char_idx_bits-1:0] char_idx;
    logic [char_idx_bits-1:0] last_char;
    logic [word_bits-1:0]     asm_word;
    logic [word_bits-1:0]     asm_next;
    logic [word_bits-1:0]     hold_word;
    logic [word_bits-1:0]     cur_word;
    logic                     hold_full;
    logic                     word_end;
    logic                     rx_load;
    logic                     tx_take;

    assign last_char = char_16 ? char_idx_bits'(chars_per_word_16 - 1)
                               : char_idx_bits'(chars_per_word_8 - 1);
    assign word_end  = cs_active && char_done && (char_idx == last_char);
    assign rx_load   = word_end && (!rx_valid || rx_ready);
    assign tx_ready  = ~hold_full;
    assign tx_take   = tx_valid && !hold_full;

    // current character merged into its lane
    always_comb begin
        asm_next = asm_word;
        if (char_16) begin
            asm_next[int'(char_idx[0])*char_max_bits +: char_max_bits] = rx_char;
        end else begin
            asm_next[int'(char_idx)*char_min_bits +: char_min_bits] =
                rx_char[char_min_bits-1:0];
        end
    end

    always_comb begin
        if (char_16) begin
            tx_char = cur_word[int'(char_idx[0])*char_max_bits +: char_max_bits];
        end else begin
            tx_char = {idle_char[char_max_bits-1:char_min_bits],
                       cur_word[int'(char_idx)*char_min_bits +: char_min_bits]};
        end
    end

    always_ff @(posedge S_REV or negedge S_RESETN) begin
        if (!S_RESETN) begin
            char_idx   <= '0;
            asm_word   <= '0;
            cur_word   <= idle_word;
            hold_full  <= 1'b0;
            rx_valid   <= 1'b0;
            rx_overrun <= 1'b0;
        end else begin
            rx_overrun <= 1'b0;
            if (rx_valid && rx_ready) begin
                rx_valid <= 1'b0;
            end
            if (tx_take) begin
                hold_full <= 1'b1;
            end
            if (!cs_active) begin
                char_idx <= '0;  // partial word is lost
                asm_word <= '0;
                cur_word <= idle_word;
            end else begin
                if (cs_start || word_end) begin
                    cur_word  <= hold_full ? hold_word : idle_word;
                    hold_full <= tx_take; // a word taken now stays held
                end
                if (word_end) begin
                    char_idx <= '0;
                    asm_word <= '0;
                    if (rx_load) begin
                        rx_valid <= 1'b1;
                    end else begin
                        rx_overrun <= 1'b1; // held word kept, new one dropped
                    end
                end else if (char_done) begin
                    char_idx <= char_idx + 1'b1;
                    asm_word <= asm_next;
                end
            end
        end
    end

    always_ff @(posedge S_REV) begin
        if (rx_load) begin
            rx_word <= asm_next;
        end
        if (tx_take) begin
            hold_word <= tx_word;
        end
    end

endmodule

/* design/spi_slave_top.sv */
module spi_slave_top
    import spi_slave_pkg::*;
(
    input  logic                 S_REV,
    input  logic                 S_RESETN,
    input  logic                 enable,
    input  logic                 cpol,
    input  logic                 cpha,
    input  logic                 lsb_first,
    input  logic                 char_16,
    input  logic                 spi_sck,
    input  logic                 spi_cs,
    input  logic                 spi_mosi,
    output logic                 spi_miso,
    input  logic                 rx_ready,
    output logic                 rx_valid,
    output logic [word_bits-1:0] rx_word,
    output logic                 rx_overrun,
    input  logic                 tx_valid,
    input  logic [word_bits-1:0] tx_word,
    output logic                 tx_ready
);

    logic                     cs_active;
    logic                     cs_start;
    logic                     sample_edge;
    logic                     shift_edge;
    logic                     mosi_s;
    logic                     char_done;
    logic [char_max_bits-1:0] rx_char;
    logic [char_max_bits-1:0] tx_char;

    spi_pin_sync u_pin_sync (
        .S_REV       (S_REV),
        .S_RESETN    (S_RESETN),
        .enable      (enable),
        .cpol        (cpol),
        .cpha        (cpha),
        .spi_sck     (spi_sck),
        .spi_cs      (spi_cs),
        .spi_mosi    (spi_mosi),
        .cs_active   (cs_active),
        .cs_start    (cs_start),
        .sample_edge (sample_edge),
        .shift_edge  (shift_edge),
        .mosi_s      (mosi_s)
    );

    spi_slave_trx_char u_trx_char (
        .S_REV       (S_REV),
        .S_RESETN    (S_RESETN),
        .cpha        (cpha),
        .lsb_first   (lsb_first),
        .char_16     (char_16),
        .cs_active   (cs_active),
        .cs_start    (cs_start),
        .sample_edge (sample_edge),
        .shift_edge  (shift_edge),
        .mosi_s      (mosi_s),
        .tx_char     (tx_char),
        .rx_char     (rx_char),
        .char_done   (char_done),
        .spi_miso    (spi_miso)
    );

    spi_char_packer u_packer (
        .S_REV      (S_REV),
        .S_RESETN   (S_RESETN),
        .char_16    (char_16),
        .cs_active  (cs_active),
        .cs_start   (cs_start),
        .char_done  (char_done),
        .rx_char    (rx_char),
        .rx_ready   (rx_ready),
        .tx_valid   (tx_valid),
        .tx_word    (tx_word),
        .rx_valid   (rx_valid),
        .rx_word    (rx_word),
        .rx_overrun (rx_overrun),
        .tx_ready   (tx_ready),
        .tx_char    (tx_char)
    );

endmodule

/* sim/spi_slave_assertions.sv */
module spi_slave_assertions
    import spi_slave_pkg::*;
(
    input logic                 S_REV,
    input logic                 S_RESETN,
    input logic                 rx_valid,
    input logic                 rx_ready,
    input logic [word_bits-1:0] rx_word,
    input logic                 rx_overrun,
    input logic                 tx_ready
);

    rx_word_held: assert property (
        @(posedge S_REV) disable iff (!S_RESETN)
        (rx_valid && !rx_ready) |=> $stable(rx_word)
    ) else $error("rx_word changed while waiting for rx_ready");

    overrun_with_valid: assert property (
        @(posedge S_REV) disable iff (!S_RESETN)
        rx_overrun |-> rx_valid
    ) else $error("rx_overrun pulsed while rx_valid was low");

    tx_ready_after_reset: assert property (
        @(posedge S_REV) $rose(S_RESETN) |-> tx_ready
    ) else $error("tx_ready low after reset release");

endmodule

bind spi_char_packer spi_slave_assertions u_assertions (
    .S_REV      (S_REV),
    .S_RESETN   (S_RESETN),
    .rx_valid   (rx_valid),
    .rx_ready   (rx_ready),
    .rx_word    (rx_word),
    .rx_overrun (rx_overrun),
    .tx_ready   (tx_ready)
);

/* sim/spi_slave_tb.sv */
module spi_slave_tb
    import spi_slave_pkg::*;
();

    localparam int sck_half   = 8;   // system cycles per sck half-period
    localparam int wait_limit = 200;

    logic                 S_REV = 1'b0;
    logic                 S_RESETN;
    logic                 enable;
    logic                 cpol;
    logic                 cpha;
    logic                 lsb_first;
    logic                 char_16;
    logic                 spi_sck;
    logic                 spi_cs;
    logic                 spi_mosi;
    logic                 spi_miso;
    logic                 rx_ready;
    logic                 rx_valid;
    logic [word_bits-1:0] rx_word;
    logic                 rx_overrun;
    logic                 tx_valid;
    logic [word_bits-1:0] tx_word;
    logic                 tx_ready;

    integer seed;
    int     test_errors;
    int     total_errors;
    int     tests_run;
    int     tests_bad;
    int     overrun_pulses = 0;

    spi_slave_top u_dut (.*);

    always #5 S_REV = ~S_REV;

    always @(negedge S_REV) begin
        if (rx_overrun) begin
            overrun_pulses <= overrun_pulses + 1;
        end
    end

    task automatic half_period();
        repeat (sck_half) @(negedge S_REV);
    endtask

    task automatic mismatch(input string test, input string what,
                            input logic [word_bits-1:0] exp, input logic [word_bits-1:0] got);
        $display("** Error %s: %s expected %h, actual %h", test, what, exp, got);
        test_errors++;
    endtask

    task automatic problem(input string test, input string text);
        $display("%s: %s", test, text);
        test_errors++;
    endtask

    task automatic finish_test(input string test);
        tests_run++;
        total_errors += test_errors;
        if (test_errors == 0) begin
            $display("%s: PASS", test);
        end else begin
            tests_bad++;
            $display("%s: FAIL with %0d errors", test, test_errors);
        end
        test_errors = 0;
    endtask

    // sck idles at cpol
    task automatic set_mode(input logic pol, input logic pha, input logic lsb, input logic wide);
        cpol      = pol;
        cpha      = pha;
        lsb_first = lsb;
        char_16   = wide;
        spi_sck   = pol;
        repeat (4) @(negedge S_REV);
    endtask

    task automatic write_tx(input string test, input logic [word_bits-1:0] word);
        int n;
        n        = 0;
        tx_valid = 1'b1;
        tx_word  = word;
        while (!tx_ready && n < wait_limit) begin
            @(negedge S_REV);
            n++;
        end
        if (!tx_ready)
            problem(test, "timed out waiting for tx_ready");
        @(negedge S_REV);
        tx_valid = 1'b0;
    endtask

    task automatic read_rx(input string test, output logic [word_bits-1:0] word);
        int n;
        n    = 0;
        word = 'x;
        while (!rx_valid && n < wait_limit) begin
            @(negedge S_REV);
            n++;
        end
        if (!rx_valid) begin
            problem(test, "timed out waiting for rx_valid");
        end else begin
            word     = rx_word;
            rx_ready = 1'b1;
            @(negedge S_REV);
            rx_ready = 1'b0;
        end
    endtask

    // one cs frame, character k sits in lane k of the word
    task automatic spi_frame(input int nchars, input logic [word_bits-1:0] mosi_data,
                             output logic [word_bits-1:0] miso_data);
        int width;
        int k;
        int j;
        int pos;
        width     = char_16 ? 16 : 8;
        miso_data = '0;
        spi_cs    = 1'b0;
        half_period(); // cs setup before the first sck edge
        for (k = 0; k < nchars; k++) begin
            for (j = 0; j < width; j++) begin
                pos = k * width + (lsb_first ? j : width - 1 - j);
                if (!cpha) begin
                    spi_mosi = mosi_data[pos];
                    half_period();
                    miso_data[pos] = spi_miso; // leading edge samples
                    spi_sck        = ~spi_sck;
                    half_period();
                    spi_sck = ~spi_sck;
                end else begin
                    spi_sck  = ~spi_sck;
                    spi_mosi = mosi_data[pos];
                    half_period();
                    miso_data[pos] = spi_miso; // trailing edge samples
                    spi_sck        = ~spi_sck;
                    half_period();
                end
            end
        end
        half_period();
        spi_cs = 1'b1;
        half_period();
    endtask

    task automatic after_reset();
        logic [word_bits-1:0] tx_w;
        logic [word_bits-1:0] rx_w;
        logic [word_bits-1:0] miso_w;
        logic [word_bits-1:0] got;
        if (rx_valid !== 1'b0)
            mismatch("after_reset", "rx_valid", 32'h0, 32'(rx_valid));
        if (tx_ready !== 1'b1)
            mismatch("after_reset", "tx_ready", 32'h1, 32'(tx_ready));
        if (spi_miso !== 1'b1)
            mismatch("after_reset", "spi_miso", 32'h1, 32'(spi_miso));
        set_mode(1'b0, 1'b0, 1'b0, 1'b0);
        tx_w = $random(seed);
        rx_w = $random(seed);
        write_tx("after_reset", tx_w);
        spi_frame(4, rx_w, miso_w);
        read_rx("after_reset", got);
        if (got !== rx_w)
            mismatch("after_reset", "rx_word", rx_w, got);
        if (miso_w !== tx_w)
            mismatch("after_reset", "miso word", tx_w, miso_w);
        finish_test("after_reset");
    endtask

    task automatic all_modes_16();
        logic [word_bits-1:0] tx_w;
        logic [word_bits-1:0] rx_w;
        logic [word_bits-1:0] miso_w;
        logic [word_bits-1:0] got;
        string                name;
        int                   m;
        for (m = 0; m < 4; m++) begin
            name = $sformatf("all_modes_16 mode %0d", m);
            set_mode(m[1], m[0], 1'b1, 1'b1);
            tx_w = $random(seed);
            rx_w = $random(seed);
            write_tx(name, tx_w);
            spi_frame(2, rx_w, miso_w);
            read_rx(name, got);
            if (got !== rx_w)
                mismatch(name, "rx_word", rx_w, got);
            if (miso_w !== tx_w)
                mismatch(name, "miso word", tx_w, miso_w);
        end
        finish_test("all_modes_16");
    endtask

    task automatic empty_tx();
        logic [word_bits-1:0] rx_w;
        logic [word_bits-1:0] miso_w;
        logic [word_bits-1:0] got;
        set_mode(1'b0, 1'b0, 1'b0, 1'b0);
        if (tx_ready !== 1'b1)
            mismatch("empty_tx", "tx_ready", 32'h1, 32'(tx_ready));
        rx_w = $random(seed);
        spi_frame(4, rx_w, miso_w);
        read_rx("empty_tx", got);
        if (got !== rx_w)
            mismatch("empty_tx", "rx_word", rx_w, got);
        if (miso_w !== 32'hffff_ffff)
            mismatch("empty_tx", "miso word", 32'hffff_ffff, miso_w);
        finish_test("empty_tx");
    endtask

    task automatic back_pressure();
        logic [word_bits-1:0] w1;
        logic [word_bits-1:0] w2;
        logic [word_bits-1:0] miso_w;
        logic [word_bits-1:0] got;
        int                   base;
        int                   n;
        set_mode(1'b0, 1'b0, 1'b0, 1'b0);
        base = overrun_pulses;
        w1   = $random(seed);
        w2   = $random(seed);
        spi_frame(4, w1, miso_w);
        spi_frame(4, w2, miso_w);
        if (overrun_pulses - base != 1)
            mismatch("back_pressure", "overrun pulses", 32'h1, 32'(overrun_pulses - base));
        if (rx_word !== w1)
            mismatch("back_pressure", "held rx_word", w1, rx_word);
        read_rx("back_pressure", got);
        if (got !== w1)
            mismatch("back_pressure", "rx_word", w1, got);
        for (n = 0; n < 40; n++) begin
            @(negedge S_REV);
            if (rx_valid)
                problem("back_pressure", "a second word appeared after the overrun");
        end
        finish_test("back_pressure");
    endtask

    task automatic cs_mid_word();
        logic [word_bits-1:0] junk;
        logic [word_bits-1:0] rx_w;
        logic [word_bits-1:0] miso_w;
        logic [word_bits-1:0] got;
        set_mode(1'b0, 1'b0, 1'b0, 1'b0);
        junk = $random(seed);
        rx_w = $random(seed);
        spi_frame(2, junk, miso_w); // cs rises after two characters
        if (rx_valid !== 1'b0)
            mismatch("cs_mid_word", "rx_valid after partial word", 32'h0, 32'(rx_valid));
        spi_frame(4, rx_w, miso_w);
        read_rx("cs_mid_word", got);
        if (got !== rx_w)
            mismatch("cs_mid_word", "rx_word", rx_w, got);
        finish_test("cs_mid_word");
    endtask

    initial begin
        seed         = 32'h7e6e9e1f;
        test_errors  = 0;
        total_errors = 0;
        tests_run    = 0;
        tests_bad    = 0;
        S_RESETN     = 1'b0;
        enable       = 1'b1;
        cpol         = 1'b0;
        cpha         = 1'b0;
        lsb_first    = 1'b0;
        char_16      = 1'b0;
        spi_sck      = 1'b0;
        spi_cs       = 1'b1;
        spi_mosi     = 1'b0;
        rx_ready     = 1'b0;
        tx_valid     = 1'b0;
        tx_word      = '0;
        repeat (8) @(negedge S_REV);
        S_RESETN = 1'b1;
        @(negedge S_REV);
        after_reset();
        all_modes_16();
        empty_tx();
        back_pressure();
        cs_mid_word();
        $display("summary: %0d tests run, %0d with errors, %0d errors in all",
                 tests_run, tests_bad, total_errors);
        if (total_errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* tb.f */
design/spi_slave_pkg.sv
design/spi_pin_sync.sv
design/spi_slave_trx_char.sv
design/spi_char_packer.sv
design/spi_slave_top.sv
sim/spi_slave_assertions.sv
sim/spi_slave_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module spi_slave_tb -f tb.f -o spi_slave_sim \
    || { echo "verilator build error"; exit 1; }
./obj_dir/spi_slave_sim > sim.log 2>&1 || echo "simulator returned an error status" >> sim.log
cat sim.log
grep -q "tests failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "%Error" sim.log && { echo "FAIL: assertion or runtime error"; exit 1; }
grep -q "all tests passed" sim.log || { echo "FAIL: no pass message in log"; exit 1; }
echo "PASS"
